//--- source/decode_pkg.sv
package decode_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [1:0]  reg_dst_t;
	typedef logic [13:0] ls_type_t;   // lwl lwr swl swr ll sc lw lh lhu lb lbu sw sh sb
	typedef logic [6:0]  cache_op_t;
	typedef logic [3:0]  tlb_op_t;    // tlbwr tlbwi tlbr tlbp
	typedef logic [1:0]  exc_code_t;
	typedef logic [1:0]  lane_idx_t;

	localparam reg_dst_t DST_RD = 2'b00, DST_RT = 2'b01, DST_RA = 2'b10;

	localparam exc_code_t EXC_NONE = 2'd0, EXC_RI = 2'd1, EXC_BREAK = 2'd2,
		EXC_SYSCALL = 2'd3;

	// major opcodes
	localparam opcode_t
		EXE_R_TYPE = 6'b000000, EXE_REGIMM = 6'b000001, EXE_J     = 6'b000010,
		EXE_JAL    = 6'b000011, EXE_BEQ    = 6'b000100, EXE_BNE   = 6'b000101,
		EXE_BLEZ   = 6'b000110, EXE_BGTZ   = 6'b000111, EXE_ADDI  = 6'b001000,
		EXE_ADDIU  = 6'b001001, EXE_SLTI   = 6'b001010, EXE_SLTIU = 6'b001011,
		EXE_ANDI   = 6'b001100, EXE_ORI    = 6'b001101, EXE_XORI  = 6'b001110,
		EXE_LUI    = 6'b001111, EXE_COP0   = 6'b010000, EXE_BEQL  = 6'b010100,
		EXE_BNEL   = 6'b010101, EXE_BLEZL  = 6'b010110, EXE_BGTZL = 6'b010111,
		EXE_SPECIAL2 = 6'b011100, EXE_LB   = 6'b100000, EXE_LH    = 6'b100001,
		EXE_LWL    = 6'b100010, EXE_LW     = 6'b100011, EXE_LBU   = 6'b100100,
		EXE_LHU    = 6'b100101, EXE_LWR    = 6'b100110, EXE_SB    = 6'b101000,
		EXE_SH     = 6'b101001, EXE_SWL    = 6'b101010, EXE_SW    = 6'b101011,
		EXE_SWR    = 6'b101110, EXE_CACHE  = 6'b101111, EXE_LL    = 6'b110000,
		EXE_PREF   = 6'b110011, EXE_SC     = 6'b111000;

	// SPECIAL funct
	localparam funct_t
		EXE_SLL   = 6'b000000, EXE_SRL  = 6'b000010, EXE_SRA     = 6'b000011,
		EXE_SLLV  = 6'b000100, EXE_SRLV = 6'b000110, EXE_SRAV    = 6'b000111,
		EXE_JR    = 6'b001000, EXE_JALR = 6'b001001, EXE_MOVZ    = 6'b001010,
		EXE_MOVN  = 6'b001011, EXE_SYNC = 6'b001111, EXE_SYSCALL = 6'b001100,
		EXE_BREAK = 6'b001101, EXE_MFHI = 6'b010000, EXE_MTHI    = 6'b010001,
		EXE_MFLO  = 6'b010010, EXE_MTLO = 6'b010011, EXE_MULT    = 6'b011000,
		EXE_MULTU = 6'b011001, EXE_DIV  = 6'b011010, EXE_DIVU    = 6'b011011,
		EXE_ADD   = 6'b100000, EXE_ADDU = 6'b100001, EXE_SUB     = 6'b100010,
		EXE_SUBU  = 6'b100011, EXE_AND  = 6'b100100, EXE_OR      = 6'b100101,
		EXE_XOR   = 6'b100110, EXE_NOR  = 6'b100111, EXE_SLT     = 6'b101010,
		EXE_SLTU  = 6'b101011, EXE_TGE  = 6'b110000, EXE_TGEU    = 6'b110001,
		EXE_TLT   = 6'b110010, EXE_TLTU = 6'b110011, EXE_TEQ     = 6'b110100,
		EXE_TNE   = 6'b110110;

	// SPECIAL2 funct
	localparam funct_t
		EXE_MADD = 6'b000000, EXE_MADDU = 6'b000001, EXE_MUL = 6'b000010,
		EXE_MSUB = 6'b000100, EXE_MSUBU = 6'b000101, EXE_CLZ = 6'b100000,
		EXE_CLO  = 6'b100001;

	// COP0 co-functions
	localparam funct_t
		EXE_TLBR = 6'b000001, EXE_TLBWI = 6'b000010, EXE_TLBWR = 6'b000110,
		EXE_TLBP = 6'b001000, EXE_ERET  = 6'b011000, EXE_WAIT  = 6'b100000;

	// REGIMM rt
	localparam reg_idx_t
		EXE_BLTZ    = 5'b00000, EXE_BGEZ    = 5'b00001, EXE_BLTZL  = 5'b00010,
		EXE_BGEZL   = 5'b00011, EXE_TGEI    = 5'b01000, EXE_TGEIU  = 5'b01001,
		EXE_TLTI    = 5'b01010, EXE_TLTIU   = 5'b01011, EXE_TEQI   = 5'b01100,
		EXE_TNEI    = 5'b01110, EXE_BLTZAL  = 5'b10000, EXE_BGEZAL = 5'b10001,
		EXE_BLTZALL = 5'b10010, EXE_BGEZALL = 5'b10011;

	localparam reg_idx_t EXE_MFC0 = 5'b00000, EXE_MTC0 = 5'b00100;   // COP0 rs

	// cache op in the rt field
	localparam reg_idx_t
		I_IndexInvalid  = 5'b00000, D_IndexWriteBackInvalid = 5'b00001,
		I_IndexStoreTag = 5'b01000, D_IndexStoreTag         = 5'b01001,
		I_HitInvalid    = 5'b10000, D_HitInvalid            = 5'b10001,
		D_HitWriteBackInvalid = 5'b10101;

endpackage

//--- source/lane_ctrl_if.sv
interface lane_ctrl_if import decode_pkg::*; ();

	logic      valid;
	logic      sign_ext, is_div, is_mult;
	ls_type_t  l_s_type;
	logic [1:0] mfhi_lo;   // {mfhi, mflo}
	reg_dst_t  reg_dst;
	logic      alu_imm_sel, hilo_wen;
	logic      mem_read_en, mem_write_en, reg_write_en;
	logic      mem_to_reg, hilo_to_reg;
	logic      ri, brk, syscall, eret;
	logic      cp0_wen, cp0_to_reg;
	tlb_op_t   tlb_type;
	logic      movz, movn;
	cache_op_t cache_op;

	modport dec (
		output valid, sign_ext, is_div, is_mult, l_s_type, mfhi_lo,
		output reg_dst, alu_imm_sel, hilo_wen,
		output mem_read_en, mem_write_en, reg_write_en, mem_to_reg, hilo_to_reg,
		output ri, brk, syscall, eret,
		output cp0_wen, cp0_to_reg, tlb_type, movz, movn, cache_op
	);

	modport stage (
		input valid, sign_ext, is_div, is_mult, l_s_type, mfhi_lo,
		input reg_dst, alu_imm_sel, hilo_wen,
		input mem_read_en, mem_write_en, reg_write_en, mem_to_reg, hilo_to_reg,
		input ri, brk, syscall, eret,
		input cp0_wen, cp0_to_reg, tlb_type, movz, movn, cache_op
	);

endinterface

//--- source/fetch_slot_buffer.sv
module fetch_slot_buffer import decode_pkg::*; #(
	parameter int LANES = 2
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             stall,
	input  logic             flush,
	input  logic             fetch_valid,    // one strobe for the whole bundle
	input  instr_t           fetch_instrs [LANES],
	output instr_t           slot_instr [LANES],
	output logic [LANES-1:0] slot_valid
);

	// flush beats stall
	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			slot_valid <= '0;
		end else if (!stall) begin
			slot_valid <= {LANES{fetch_valid}};
		end
	end

	// bundle held while the stage is stalled
	always_ff @(posedge clk) begin
		if (!stall) begin
			slot_instr <= fetch_instrs;
		end
	end

endmodule

//--- source/main_decoder.sv
module main_decoder import decode_pkg::*; (
	input  instr_t   instr,
	input  logic     valid,
	lane_ctrl_if.dec ctrl
);

	opcode_t    op;
	reg_idx_t   rs;
	reg_idx_t   rt;
	funct_t     funct;
	logic       r_type, cop0, special2, is_cache;
	logic       mul, madd, maddu, msub, msubu;
	logic [3:0] rf_ctrl;    // {reg_write_en, reg_dst, alu_imm_sel}
	logic [2:0] mem_ctrl;   // {mem_to_reg, mem_read_en, mem_write_en}
	logic       ri;

	assign op    = instr[31:26];
	assign rs    = instr[25:21];
	assign rt    = instr[20:16];
	assign funct = instr[5:0];

	assign r_type   = (op == EXE_R_TYPE);
	assign cop0     = (op == EXE_COP0);
	assign special2 = (op == EXE_SPECIAL2);
	assign is_cache = (op == EXE_CACHE);

	assign ctrl.valid = valid;
	assign {ctrl.reg_write_en, ctrl.reg_dst, ctrl.alu_imm_sel} = rf_ctrl;
	assign {ctrl.mem_to_reg, ctrl.mem_read_en, ctrl.mem_write_en} = mem_ctrl;
	assign ctrl.ri = ri;

	// andi ori xori lui zero extend
	assign ctrl.sign_ext = (op[5:2] != 4'b0011);

	assign mul   = special2 && (funct == EXE_MUL);
	assign madd  = special2 && (funct == EXE_MADD);
	assign maddu = special2 && (funct == EXE_MADDU);
	assign msub  = special2 && (funct == EXE_MSUB);
	assign msubu = special2 && (funct == EXE_MSUBU);

	// mult multu div divu, then mthi mtlo
	assign ctrl.hilo_wen = (r_type && (funct[5:2] == 4'b0110
		|| (funct[5:2] == 4'b0100 && funct[0]))) || madd || maddu || msub || msubu;
	assign ctrl.hilo_to_reg = r_type && (funct[5:2] == 4'b0100) && !funct[0];
	assign ctrl.mfhi_lo = {r_type && (funct == EXE_MFHI), r_type && (funct == EXE_MFLO)};

	assign ctrl.is_div  = r_type && (funct[5:1] == 5'b01101);
	assign ctrl.is_mult = (r_type && (funct[5:1] == 5'b01100))
		|| mul || madd || maddu || msub || msubu;

	assign ctrl.cp0_wen    = cop0 && (rs == EXE_MTC0);
	assign ctrl.cp0_to_reg = cop0 && (rs == EXE_MFC0);
	assign ctrl.eret       = cop0 && (funct == EXE_ERET);
	assign ctrl.brk        = r_type && (funct == EXE_BREAK);
	assign ctrl.syscall    = r_type && (funct == EXE_SYSCALL);
	assign ctrl.movz       = r_type && (funct == EXE_MOVZ);
	assign ctrl.movn       = r_type && (funct == EXE_MOVN);

	assign ctrl.tlb_type = {
		cop0 && (funct == EXE_TLBWR),
		cop0 && (funct == EXE_TLBWI),
		cop0 && (funct == EXE_TLBR),
		cop0 && (funct == EXE_TLBP)
	};

	assign ctrl.l_s_type = {
		op == EXE_LWL, op == EXE_LWR, op == EXE_SWL, op == EXE_SWR,
		op == EXE_LL,  op == EXE_SC,  op == EXE_LW,  op == EXE_LH,
		op == EXE_LHU, op == EXE_LB,  op == EXE_LBU, op == EXE_SW,
		op == EXE_SH,  op == EXE_SB
	};

	assign ctrl.cache_op = {
		is_cache && (rt == I_IndexInvalid),
		is_cache && (rt == I_IndexStoreTag),
		is_cache && (rt == I_HitInvalid),
		is_cache && (rt == D_IndexWriteBackInvalid),
		is_cache && (rt == D_IndexStoreTag),
		is_cache && (rt == D_HitInvalid),
		is_cache && (rt == D_HitWriteBackInvalid)
	};

	always_comb begin
		ri       = 1'b0;
		rf_ctrl  = '0;
		mem_ctrl = '0;
		case (op)
			EXE_R_TYPE: begin
				case (funct)
					EXE_ADD, EXE_ADDU, EXE_SUB, EXE_SUBU, EXE_SLT, EXE_SLTU,
					EXE_AND, EXE_OR, EXE_XOR, EXE_NOR,
					EXE_SLL, EXE_SLLV, EXE_SRA, EXE_SRAV, EXE_SRL, EXE_SRLV,
					EXE_MFHI, EXE_MFLO, EXE_MOVZ, EXE_MOVN:
						rf_ctrl = {1'b1, DST_RD, 1'b0};
					EXE_JR, EXE_MULT, EXE_MULTU, EXE_DIV, EXE_DIVU, EXE_MTHI, EXE_MTLO,
					EXE_SYSCALL, EXE_BREAK, EXE_SYNC,
					EXE_TEQ, EXE_TNE, EXE_TGE, EXE_TGEU, EXE_TLT, EXE_TLTU:
						rf_ctrl = '0;
					EXE_JALR:
						rf_ctrl = {1'b1, DST_RA, 1'b0};   // always links to $31
					default: begin
						ri      = 1'b1;
						rf_ctrl = {1'b1, DST_RD, 1'b0};
					end
				endcase
			end
			EXE_ADDI, EXE_ADDIU, EXE_SLTI, EXE_SLTIU,
			EXE_ANDI, EXE_ORI, EXE_XORI, EXE_LUI:
				rf_ctrl = {1'b1, DST_RT, 1'b1};
			EXE_BEQ, EXE_BNE, EXE_BLEZ, EXE_BGTZ,
			EXE_BEQL, EXE_BNEL, EXE_BLEZL, EXE_BGTZL, EXE_PREF, EXE_J:
				rf_ctrl = '0;
			EXE_JAL:
				rf_ctrl = {1'b1, DST_RA, 1'b0};
			EXE_CACHE: begin
				case (rt)
					I_IndexInvalid, I_IndexStoreTag, I_HitInvalid,
					D_IndexWriteBackInvalid, D_IndexStoreTag, D_HitInvalid,
					D_HitWriteBackInvalid:
						rf_ctrl = {1'b0, DST_RD, 1'b1};   // alu forms the address
					default:
						ri = 1'b1;
				endcase
			end
			EXE_REGIMM: begin
				case (rt)
					EXE_BGEZAL, EXE_BLTZAL, EXE_BGEZALL, EXE_BLTZALL:
						rf_ctrl = {1'b1, DST_RA, 1'b0};
					EXE_BGEZ, EXE_BLTZ, EXE_BGEZL, EXE_BLTZL:
						rf_ctrl = '0;
					EXE_TEQI, EXE_TNEI, EXE_TGEI, EXE_TGEIU, EXE_TLTI, EXE_TLTIU:
						rf_ctrl = {1'b0, DST_RD, 1'b1};   // compare against imm
					default:
						ri = 1'b1;
				endcase
			end
			EXE_LW, EXE_LB, EXE_LBU, EXE_LH, EXE_LHU, EXE_LL, EXE_LWL, EXE_LWR: begin
				rf_ctrl  = {1'b1, DST_RT, 1'b1};
				mem_ctrl = 3'b110;
			end
			EXE_SW, EXE_SB, EXE_SH, EXE_SWL, EXE_SWR: begin
				rf_ctrl  = {1'b0, DST_RD, 1'b1};
				mem_ctrl = 3'b001;
			end
			EXE_SC: begin
				// writes the success flag back to rt
				rf_ctrl  = {1'b1, DST_RT, 1'b1};
				mem_ctrl = 3'b001;
			end
			EXE_COP0: begin
				case (rs)
					EXE_MTC0:
						rf_ctrl = '0;
					EXE_MFC0:
						rf_ctrl = {1'b1, DST_RT, 1'b0};
					default:
						ri = !(funct inside {EXE_ERET, EXE_TLBR, EXE_TLBP,
							EXE_TLBWI, EXE_TLBWR, EXE_WAIT});
				endcase
			end
			EXE_SPECIAL2: begin
				case (funct)
					EXE_MUL, EXE_CLZ, EXE_CLO:
						rf_ctrl = {1'b1, DST_RD, 1'b0};
					EXE_MADD, EXE_MADDU, EXE_MSUB, EXE_MSUBU:
						rf_ctrl = '0;   // result goes to hi/lo
					default:
						ri = 1'b1;
				endcase
			end
			default:
				ri = 1'b1;
		endcase
	end

endmodule

//--- source/decode_stage_reg.sv
module decode_stage_reg import decode_pkg::*; #(
	parameter int LANES = 2
) (
	input  logic clk, rst_n, stall, flush,
	lane_ctrl_if.stage lanes [LANES],
	output logic [LANES-1:0] id_valid, reg_write_en, alu_imm_sel, sign_ext,
	output logic [LANES-1:0] mem_read_en, mem_write_en, mem_to_reg,
	output logic [LANES-1:0] hilo_wen, hilo_to_reg, is_div, is_mult,
	output logic [LANES-1:0] cp0_wen, cp0_to_reg, eret, movz, movn,
	output logic [$bits(reg_dst_t)*LANES-1:0]  reg_dst,
	output logic [2*LANES-1:0]                 mfhi_lo,
	output logic [$bits(ls_type_t)*LANES-1:0]  l_s_type,
	output logic [$bits(tlb_op_t)*LANES-1:0]   tlb_type,
	output logic [$bits(cache_op_t)*LANES-1:0] cache_op,
	output logic      exc_valid,
	output lane_idx_t exc_lane,
	output exc_code_t exc_code
);

	logic [LANES-1:0] lane_valid, fault;
	logic [LANES-1:0] live;    // survives the squash
	logic [LANES-1:0] wr_ok;   // live and not the faulting lane
	exc_code_t        cause [LANES];
	logic             exc_hit;
	lane_idx_t        exc_lane_nxt;
	exc_code_t        exc_code_nxt;

	// oldest lane first
	always_comb begin
		exc_hit      = 1'b0;
		exc_lane_nxt = '0;
		exc_code_nxt = EXC_NONE;
		live         = lane_valid;
		wr_ok        = lane_valid;
		for (int k = 0; k < LANES; k++) begin
			if (exc_hit) begin
				live[k]  = 1'b0;
				wr_ok[k] = 1'b0;
			end else if (fault[k]) begin
				exc_hit      = 1'b1;
				exc_lane_nxt = lane_idx_t'(k);
				exc_code_nxt = cause[k];
				wr_ok[k]     = 1'b0;   // faulting lane stays visible, no side effects
			end
		end
	end

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		assign lane_valid[i] = lanes[i].valid;
		assign fault[i] = lanes[i].valid && (lanes[i].ri || lanes[i].brk || lanes[i].syscall);
		assign cause[i] = lanes[i].ri ? EXC_RI : (lanes[i].brk ? EXC_BREAK : EXC_SYSCALL);

		always_ff @(posedge clk) begin
			if (!rst_n || flush) begin
				id_valid[i]     <= 1'b0;
				reg_write_en[i] <= 1'b0;
				mem_read_en[i]  <= 1'b0;
				mem_write_en[i] <= 1'b0;
				hilo_wen[i]     <= 1'b0;
				cp0_wen[i]      <= 1'b0;
			end else if (!stall) begin
				id_valid[i]     <= live[i];
				reg_write_en[i] <= lanes[i].reg_write_en && wr_ok[i];
				mem_read_en[i]  <= lanes[i].mem_read_en && live[i];
				mem_write_en[i] <= lanes[i].mem_write_en && wr_ok[i];
				hilo_wen[i]     <= lanes[i].hilo_wen && wr_ok[i];
				cp0_wen[i]      <= lanes[i].cp0_wen && wr_ok[i];
			end
		end

		// meaningful only with id_valid
		always_ff @(posedge clk) begin
			if (!stall) begin
				reg_dst[2*i +: 2]   <= lanes[i].reg_dst;
				alu_imm_sel[i]      <= lanes[i].alu_imm_sel;
				sign_ext[i]         <= lanes[i].sign_ext;
				mem_to_reg[i]       <= lanes[i].mem_to_reg;
				hilo_to_reg[i]      <= lanes[i].hilo_to_reg;
				mfhi_lo[2*i +: 2]   <= lanes[i].mfhi_lo;
				is_div[i]           <= lanes[i].is_div;
				is_mult[i]          <= lanes[i].is_mult;
				l_s_type[14*i +: 14] <= lanes[i].l_s_type;
				cp0_to_reg[i]       <= lanes[i].cp0_to_reg;
				eret[i]             <= lanes[i].eret;
				tlb_type[4*i +: 4]  <= lanes[i].tlb_type;
				movz[i]             <= lanes[i].movz;
				movn[i]             <= lanes[i].movn;
				cache_op[7*i +: 7]  <= lanes[i].cache_op;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			exc_valid <= 1'b0;
		end else if (!stall) begin
			exc_valid <= exc_hit;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			exc_lane <= exc_lane_nxt;
			exc_code <= exc_code_nxt;
		end
	end

endmodule

//--- source/decode_top.sv
module decode_top import decode_pkg::*; #(
	parameter int LANES = 2
) (
	input  logic clk, rst_n, stall, flush,
	input  logic fetch_valid,
	input  logic [$bits(instr_t)*LANES-1:0] fetch_instrs,   // lane 0 in the low word
	output logic [LANES-1:0] id_valid, reg_write_en, alu_imm_sel, sign_ext,
	output logic [LANES-1:0] mem_read_en, mem_write_en, mem_to_reg,
	output logic [LANES-1:0] hilo_wen, hilo_to_reg, is_div, is_mult,
	output logic [LANES-1:0] cp0_wen, cp0_to_reg, eret, movz, movn,
	output logic [$bits(reg_dst_t)*LANES-1:0]  reg_dst,
	output logic [2*LANES-1:0]                 mfhi_lo,
	output logic [$bits(ls_type_t)*LANES-1:0]  l_s_type,
	output logic [$bits(tlb_op_t)*LANES-1:0]   tlb_type,
	output logic [$bits(cache_op_t)*LANES-1:0] cache_op,
	output logic      exc_valid,
	output lane_idx_t exc_lane,
	output exc_code_t exc_code
);

	instr_t           fetch_words [LANES];
	instr_t           slot_instr [LANES];
	logic [LANES-1:0] slot_valid;

	lane_ctrl_if lane_ctrl [LANES] ();

	fetch_slot_buffer #(.LANES(LANES)) u_slots (
		.clk          (clk),
		.rst_n        (rst_n),
		.stall        (stall),
		.flush        (flush),
		.fetch_valid  (fetch_valid),
		.fetch_instrs (fetch_words),
		.slot_instr   (slot_instr),
		.slot_valid   (slot_valid)
	);

	// one decoder per slot
	for (genvar i = 0; i < LANES; i++) begin : g_dec
		assign fetch_words[i] = fetch_instrs[32*i +: 32];

		main_decoder u_dec (
			.instr (slot_instr[i]),
			.valid (slot_valid[i]),
			.ctrl  (lane_ctrl[i])
		);
	end

	decode_stage_reg #(.LANES(LANES)) u_stage (
		.lanes (lane_ctrl),
		.*
	);

endmodule

//--- sim/decode_tb.sv
module decode_tb import decode_pkg::*;;

	localparam int PERIOD     = 20;
	localparam int TIME_LIMIT = 100000;
	localparam int RST_WAIT   = 50;

	// expected values of one lane
	typedef struct packed {
		logic v, rwe;
		logic [1:0] dst;
		logic imm, zx, mrd, mwr, m2r, hw;   // zx is zero extension
		logic [1:0] hl;                     // {mfhi, mflo}
		logic h2r, dv, ml, mz, mn;
		logic c0w, c0r, er;
		logic [13:0] ls;
		logic [6:0] co;
		logic [3:0] tlb;
	} lane_exp_t;

	typedef struct packed {
		instr_t i0, i1;
		logic stall, flush;
		lane_exp_t e0, e1;
		logic xv;
		lane_idx_t xl;
		exc_code_t xc;
	} vec_t;

	localparam lane_exp_t OFF     = '0;
	localparam lane_exp_t FAULT   = '{v: 1'b1, default: 0};
	localparam lane_exp_t ADD_RD  = '{v: 1'b1, rwe: 1'b1, dst: DST_RD, default: 0};
	localparam lane_exp_t IMM_RT  = '{v: 1'b1, rwe: 1'b1, dst: DST_RT, imm: 1'b1, default: 0};
	localparam lane_exp_t ZEXT_RT = '{v: 1'b1, rwe: 1'b1, dst: DST_RT, imm: 1'b1, zx: 1'b1,
		default: 0};
	localparam lane_exp_t LINK    = '{v: 1'b1, rwe: 1'b1, dst: DST_RA, default: 0};
	localparam lane_exp_t HILO_W  = '{v: 1'b1, hw: 1'b1, default: 0};
	localparam lane_exp_t MUL_HL  = '{v: 1'b1, hw: 1'b1, ml: 1'b1, default: 0};
	localparam lane_exp_t DIV_HL  = '{v: 1'b1, hw: 1'b1, dv: 1'b1, default: 0};

	logic clk, rst_n, stall, flush, fetch_valid;
	logic [63:0] fetch_instrs;
	logic [1:0] id_valid, reg_write_en, alu_imm_sel, sign_ext, mem_read_en, mem_write_en;
	logic [1:0] mem_to_reg, hilo_wen, hilo_to_reg, is_div, is_mult;
	logic [1:0] cp0_wen, cp0_to_reg, eret, movz, movn;
	logic [3:0] reg_dst, mfhi_lo;
	logic [27:0] l_s_type;
	logic [7:0] tlb_type;
	logic [13:0] cache_op;
	logic exc_valid;
	lane_idx_t exc_lane;
	exc_code_t exc_code;

	vec_t vecs [$];
	int errors, test_errors;

	decode_top #(.LANES(2)) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
	end

	task automatic add(instr_t i0, instr_t i1, logic st, logic fl, lane_exp_t e0,
		lane_exp_t e1, logic xv = 1'b0, lane_idx_t xl = '0, exc_code_t xc = EXC_NONE);
		vec_t v;
		v = '{i0: i0, i1: i1, stall: st, flush: fl, e0: e0, e1: e1,
			xv: xv, xl: xl, xc: xc};
		vecs.push_back(v);
	endtask

	task automatic give_up(string why);
		$display("timeout: %s", why);
		$display("Verification failed");
		$finish;
	endtask

	task automatic wait_edges(int n);
		int waited;
		waited = 0;
		while (waited < n && $time <= TIME_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (waited < n) give_up("clock edges stopped arriving in time");
	endtask

	task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
		assert (act === exp) else begin
			$display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_lane(int l, lane_exp_t e);
		compare($sformatf("id_valid[%0d]", l), e.v, id_valid[l]);
		compare($sformatf("reg_write_en[%0d]", l), e.rwe, reg_write_en[l]);
		compare($sformatf("mem_read_en[%0d]", l), e.mrd, mem_read_en[l]);
		compare($sformatf("mem_write_en[%0d]", l), e.mwr, mem_write_en[l]);
		compare($sformatf("hilo_wen[%0d]", l), e.hw, hilo_wen[l]);
		compare($sformatf("cp0_wen[%0d]", l), e.c0w, cp0_wen[l]);
		if (e.v) begin   // data fields only mean something on a live lane
			if (e.rwe) compare($sformatf("reg_dst[%0d]", l), e.dst, reg_dst[2*l +: 2]);
			compare($sformatf("alu_imm_sel[%0d]", l), e.imm, alu_imm_sel[l]);
			compare($sformatf("sign_ext[%0d]", l), !e.zx, sign_ext[l]);
			compare($sformatf("mem_to_reg[%0d]", l), e.m2r, mem_to_reg[l]);
			compare($sformatf("mfhi_lo[%0d]", l), e.hl, mfhi_lo[2*l +: 2]);
			compare($sformatf("hilo_to_reg[%0d]", l), e.h2r, hilo_to_reg[l]);
			compare($sformatf("is_div[%0d]", l), e.dv, is_div[l]);
			compare($sformatf("is_mult[%0d]", l), e.ml, is_mult[l]);
			compare($sformatf("movz[%0d]", l), e.mz, movz[l]);
			compare($sformatf("movn[%0d]", l), e.mn, movn[l]);
			compare($sformatf("cp0_to_reg[%0d]", l), e.c0r, cp0_to_reg[l]);
			compare($sformatf("eret[%0d]", l), e.er, eret[l]);
			compare($sformatf("l_s_type[%0d]", l), e.ls, l_s_type[14*l +: 14]);
			compare($sformatf("cache_op[%0d]", l), e.co, cache_op[7*l +: 7]);
			compare($sformatf("tlb_type[%0d]", l), e.tlb, tlb_type[4*l +: 4]);
		end
	endtask

	initial begin
		vec_t cur, last;
		int waited;
		stall        = 1'b0;
		flush        = 1'b0;
		fetch_valid  = 1'b0;
		fetch_instrs = '0;
		errors       = 0;
		last         = '0;

		add(32'h00221820, 32'h2485FFFF, 0, 0, ADD_RD, IMM_RT);    // add, addiu
		add(32'h34221234, 32'h3C07ABCD, 0, 0, ZEXT_RT, ZEXT_RT);  // ori, lui
		add(32'h0C000100, 32'h0080F809, 0, 0, LINK, LINK);        // jal, jalr
		add(32'h8FA20008, 32'hA0830000, 0, 0,                     // lw, sb
			'{v: 1, rwe: 1, dst: DST_RT, imm: 1, mrd: 1, m2r: 1, ls: 14'h0080, default: 0},
			'{v: 1, imm: 1, mwr: 1, ls: 14'h0001, default: 0});
		add(32'h94260002, 32'hE1280000, 0, 0,                     // lhu, sc
			'{v: 1, rwe: 1, dst: DST_RT, imm: 1, mrd: 1, m2r: 1, ls: 14'h0020, default: 0},
			'{v: 1, rwe: 1, dst: DST_RT, imm: 1, mwr: 1, ls: 14'h0100, default: 0});
		add(32'h40846000, 32'h40056000, 0, 0, '{v: 1, c0w: 1, default: 0},
			'{v: 1, rwe: 1, dst: DST_RT, c0r: 1, default: 0});  // mtc0, mfc0
		add(32'h42000018, 32'h42000006, 0, 0, '{v: 1, er: 1, default: 0},
			'{v: 1, tlb: 4'b1000, default: 0});                 // eret, tlbwr
		add(32'h42000002, 32'h42000001, 0, 0, '{v: 1, tlb: 4'b0100, default: 0},
			'{v: 1, tlb: 4'b0010, default: 0});                 // tlbwi, tlbr
		add(32'h42000008, 32'hBC950000, 0, 0, '{v: 1, tlb: 4'b0001, default: 0},
			'{v: 1, imm: 1, co: 7'b0000001, default: 0});       // tlbp, cache
		add(32'h00220018, 32'h00001810, 0, 0, MUL_HL,
			'{v: 1, rwe: 1, dst: DST_RD, hl: 2'b10, h2r: 1, default: 0}); // mult, mfhi
		add(32'h70220000, 32'h00800011, 0, 0, MUL_HL, HILO_W);    // madd, mthi
		add(32'h0022001A, 32'h00002812, 0, 0, DIV_HL,
			'{v: 1, rwe: 1, dst: DST_RD, hl: 2'b01, h2r: 1, default: 0}); // div, mflo
		add(32'h0022180A, 32'h0022180B, 0, 0,                     // movz, movn
			'{v: 1, rwe: 1, dst: DST_RD, mz: 1, default: 0},
			'{v: 1, rwe: 1, dst: DST_RD, mn: 1, default: 0});
		add(32'hFC000000, 32'h00221820, 0, 0, FAULT, OFF, 1, 0, EXC_RI);
		add(32'h2485FFFF, 32'h0000000D, 0, 0, IMM_RT, FAULT, 1, 1, EXC_BREAK);
		add(32'h00221820, 32'hBC820000, 0, 0, ADD_RD, FAULT, 1, 1, EXC_RI);
		add(32'h04240000, 32'h0000000C, 0, 0, FAULT, OFF, 1, 0, EXC_RI);
		add(32'h00221820, 32'h8FA20008, 1, 0, OFF, OFF);          // stalled, ignored
		add(32'h00221820, 32'h8FA20008, 0, 1, OFF, OFF);
		add(32'h0000000C, 32'h8FA20008, 0, 0, FAULT, OFF, 1, 0, EXC_SYSCALL);

		waited = 0;
		while (rst_n !== 1'b1 && waited < RST_WAIT) begin
			@(posedge clk);
			waited++;
		end
		if (rst_n !== 1'b1) give_up("reset was never released");
		@(negedge clk);
		test_errors = 0;
		check_lane(0, OFF);
		check_lane(1, OFF);
		compare("exc_valid", 1'b0, exc_valid);
		$display("test 0 (after reset): %s", test_errors == 0 ? "ok" : "mismatch");

		foreach (vecs[t]) begin
			test_errors = 0;
			wait_edges(1);
			fetch_instrs <= {vecs[t].i1, vecs[t].i0};
			fetch_valid  <= 1'b1;
			stall        <= vecs[t].stall;
			flush        <= vecs[t].flush;
			cur = vecs[t].stall ? last : vecs[t];   // stall holds what was there
			wait_edges(2);
			@(negedge clk);
			check_lane(0, cur.e0);
			check_lane(1, cur.e1);
			compare("exc_valid", cur.xv, exc_valid);
			if (cur.xv) begin
				compare("exc_lane", cur.xl, exc_lane);
				compare("exc_code", cur.xc, exc_code);
			end
			last = cur;
			$display("test %0d: %s, %0d mismatches", t + 1,
				test_errors == 0 ? "ok" : "bad", test_errors);
		end

		$display("%0d tests run, %0d mismatches in total", vecs.size() + 1, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- flist.f
source/decode_pkg.sv
source/lane_ctrl_if.sv
source/fetch_slot_buffer.sv
source/main_decoder.sv
source/decode_stage_reg.sv
source/decode_top.sv
sim/decode_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module decode_tb -o decode_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/decode_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Verification passed" sim.log; then
	exit 0
fi
exit 1
